//--- flist.f
hdl/id_pkg.sv
hdl/pre_decoder.sv
hdl/fetch_buffer.sv
hdl/inst_decoder.sv
hdl/id_stage.sv
sim/tb_id_stage.sv

//--- hdl/fetch_buffer.sv
// two-bank interleaved instruction queue between pre-decode and decode, 0 to 2 in and out per cycle
module fetch_buffer #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic [1:0]           push_cnt,
    input  id_pkg::fetch_entry_t push_e0,
    input  id_pkg::fetch_entry_t push_e1,
    input  logic [1:0]           pop_cnt,
    output id_pkg::fetch_entry_t head0,
    output id_pkg::fetch_entry_t head1,
    output logic [1:0]           head_valid,
    output logic                 full
);

    localparam int PTR_W = $clog2(BUF_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    // one slot per bank stays unused so that empty and full differ
    id_pkg::fetch_entry_t mem [2][BUF_DEPTH];

    ptr_t       rd_ptr [2];
    ptr_t       wr_ptr [2];
    ptr_t       free_cnt [2];
    logic [1:0] empty;
    logic [1:0] really_full;
    logic [1:0] near_full;
    logic [1:0] push_req;
    logic [1:0] pop_do;
    logic       push_ok;
    logic       push_sel;   // bank that takes the older incoming entry
    logic       pop_sel;    // bank holding the oldest queued entry

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            empty[b]       = rd_ptr[b] == wr_ptr[b];
            free_cnt[b]    = rd_ptr[b] - wr_ptr[b] - 1'b1;
            really_full[b] = free_cnt[b] == '0;
            near_full[b]   = free_cnt[b] <= ptr_t'(3);   // fetch can still land two more groups
            push_req[b]    = (push_cnt == 2'd2) || (push_cnt == 2'd1 && push_sel == 1'(b));
            pop_do[b]      = ((pop_cnt == 2'd2) || (pop_cnt == 2'd1 && pop_sel == 1'(b)))
                             && !empty[b];
        end
    end

    assign push_ok = !(|really_full);
    assign full    = |near_full;

    // entries are written in whichever order push_sel says
    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (push_req[b] && push_ok) begin
                mem[b][wr_ptr[b]] <= (push_sel == 1'(b)) ? push_e0 : push_e1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int b = 0; b < 2; b++) begin
                rd_ptr[b] <= '0;
                wr_ptr[b] <= '0;
            end
            push_sel <= 1'b0;
            pop_sel  <= 1'b0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (pop_do[b]) begin
                    rd_ptr[b] <= rd_ptr[b] + 1'b1;
                end
                if (push_req[b] && push_ok) begin
                    wr_ptr[b] <= wr_ptr[b] + 1'b1;
                end
            end
            if (push_cnt == 2'd1 && push_ok) begin
                push_sel <= !push_sel;   // odd push, next group starts in the other bank
            end
            if (pop_do[0] ^ pop_do[1]) begin
                pop_sel <= !pop_sel;
            end
        end
    end

    // bank pop_sel never holds fewer entries than the other one
    assign head0         = mem[pop_sel][rd_ptr[pop_sel]];
    assign head1         = mem[!pop_sel][rd_ptr[!pop_sel]];
    assign head_valid[0] = !empty[pop_sel];
    assign head_valid[1] = !empty[pop_sel] && !empty[!pop_sel];

    // upstream ignored full for too long, the group is lost
    a_push_not_full: assert property (@(posedge clk) disable iff (!rst_n || flush)
        (push_cnt != 2'd0) |-> !(|really_full))
        else $error("push dropped, bank really full");

    a_pop_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        pop_cnt <= {1'b0, head_valid[0]} + {1'b0, head_valid[1]})
        else $error("pop of %0d with head_valid %b", pop_cnt, head_valid);

endmodule

//--- hdl/id_pkg.sv
// shared widths, encodings and bundles for the LA32 decode stage; modules refer to it by scoped name
package id_pkg;

    typedef logic [31:0] word_t;    // instruction word, pc or address
    typedef logic [4:0]  reg_idx_t;
    typedef logic [1:0]  plv_t;     // 0 is kernel
    typedef logic [6:0]  exc_t;     // 0 means no exception
    typedef logic [1:0]  br_cat_t;

    // branch category as reported to the predictor
    localparam br_cat_t cat_none   = 2'd0;
    localparam br_cat_t cat_cond   = 2'd1;   // beq / bne
    localparam br_cat_t cat_direct = 2'd2;   // b / bl
    localparam br_cat_t cat_jirl   = 2'd3;

    // exception codes raised by the decoder
    localparam exc_t exc_sys = 7'h0b;
    localparam exc_t exc_brk = 7'h0c;
    localparam exc_t exc_ine = 7'h0d;
    localparam exc_t exc_ipe = 7'h0e;

    localparam word_t inst_nop  = 32'h0280_0000;   // addi.w r0,r0,0
    localparam word_t inst_ertn = 32'h0648_3800;

    // major opcode fields, suffix gives the field width
    localparam logic [16:0] opc17_add     = 17'h00020;   // inst[31:15]
    localparam logic [16:0] opc17_sub     = 17'h00022;
    localparam logic [16:0] opc17_break   = 17'h00054;
    localparam logic [16:0] opc17_syscall = 17'h00056;
    localparam logic [9:0]  opc10_addi    = 10'h00a;     // inst[31:22]
    localparam logic [9:0]  opc10_ld      = 10'h0a2;
    localparam logic [9:0]  opc10_st      = 10'h0a6;
    localparam logic [6:0]  opc7_lu12i    = 7'h0a;       // inst[31:25]
    localparam logic [5:0]  opc6_jirl     = 6'h13;       // inst[31:26]
    localparam logic [5:0]  opc6_b        = 6'h14;
    localparam logic [5:0]  opc6_bl       = 6'h15;
    localparam logic [5:0]  opc6_beq      = 6'h16;
    localparam logic [5:0]  opc6_bne      = 6'h17;

    typedef enum logic [3:0] {
        op_none, op_add, op_sub, op_addi, op_lu12i, op_ld, op_st,
        op_beq, op_bne, op_b, op_bl, op_jirl, op_syscall, op_break, op_ertn
    } op_t;

    typedef struct packed {
        op_t  op;
        logic use_imm;     // second operand is imm
        logic writes_rd;
        logic privileged;  // needs plv 0
    } uop_t;

    localparam uop_t uop_none = '{op_none, 1'b0, 1'b0, 1'b0};

    // one fetch group from the instruction fetch stage
    typedef struct packed {
        logic  valid;
        word_t inst0;
        word_t inst1;
        word_t pc;         // bit 2 set means inst0 is not part of the group
        word_t pc_next;
        exc_t  exc;
        word_t badv;
        logic  unknown0;   // predictor had no entry for this word
        logic  unknown1;
        logic  first_jmp;  // inst0 was predicted taken, inst1 is dead
    } fetch_pair_t;

    typedef struct packed {
        word_t inst;
        word_t pc;
        word_t pc_next;
        exc_t  exc;
        word_t badv;
        logic  unknown;
    } fetch_entry_t;

    typedef struct packed {
        logic     valid;
        uop_t     uop;
        word_t    imm;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        word_t    pc;
        word_t    pc_next;
        exc_t     exc;
        word_t    badv;
        logic     unknown;
    } dec_slot_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        word_t   target0;
        word_t   target1;
        br_cat_t cat0;
        br_cat_t cat1;
    } bp_feedback_t;

endpackage

//--- hdl/id_stage.sv
// decode stage top: pre-decode redirect, NOP drop, fetch buffer and two instruction decoders
module id_stage #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  id_pkg::fetch_pair_t  fetch,
    input  id_pkg::plv_t         plv,
    input  logic [1:0]           read_en,   // pop count 0, 1 or 2
    output logic                 full,
    output id_pkg::dec_slot_t    out0,
    output id_pkg::dec_slot_t    out1,
    output id_pkg::bp_feedback_t bp_fb,
    output logic                 set_pc,
    output id_pkg::word_t        redirect_pc
);

    id_pkg::br_cat_t      cat0, cat1;
    id_pkg::word_t        offset0, offset1;
    id_pkg::word_t        target0, target1;
    id_pkg::word_t        pc1;
    id_pkg::word_t        pc_next_last;
    id_pkg::fetch_entry_t slot0_e, slot1_e;
    id_pkg::fetch_entry_t push_e0, push_e1;
    id_pkg::fetch_entry_t head0, head1;
    logic [1:0]           head_valid;
    logic [1:0]           push_cnt;
    logic                 valid0, valid1_pre, valid1;
    logic                 jump0, jump1;
    logic                 redirect0, redirect1;

    // a faulting group is kept even if the word looks like a NOP
    assign valid0     = fetch.valid && !fetch.pc[2]
                        && (fetch.inst0 != id_pkg::inst_nop || fetch.exc != '0);
    assign valid1_pre = fetch.valid && !fetch.first_jmp
                        && (fetch.inst1 != id_pkg::inst_nop || fetch.exc != '0);

    pre_decoder u_pre0 (.inst(fetch.inst0), .cat(cat0), .offset(offset0));
    pre_decoder u_pre1 (.inst(fetch.inst1), .cat(cat1), .offset(offset1));

    assign pc1     = {fetch.pc[31:3], 3'b100};
    assign target0 = fetch.pc + offset0;
    assign target1 = pc1 + offset1;

    // static guess: direct jumps and backward conditionals are taken
    assign jump0 = cat0 == id_pkg::cat_direct || (cat0 == id_pkg::cat_cond && offset0[31]);
    assign jump1 = cat1 == id_pkg::cat_direct || (cat1 == id_pkg::cat_cond && offset1[31]);

    assign redirect0   = valid0 && fetch.unknown0 && jump0;
    assign redirect1   = valid1_pre && fetch.unknown1 && jump1 && !redirect0;
    assign set_pc      = redirect0 || redirect1;
    assign redirect_pc = redirect0 ? target0 : target1;

    assign valid1       = valid1_pre && !redirect0;   // fall-through word after a taken slot 0
    assign pc_next_last = set_pc ? redirect_pc : fetch.pc_next;

    assign slot0_e = '{inst: fetch.inst0, pc: fetch.pc,
                       pc_next: valid1 ? fetch.pc + 32'd4 : pc_next_last,
                       exc: fetch.exc, badv: fetch.badv, unknown: fetch.unknown0};
    assign slot1_e = '{inst: fetch.inst1, pc: pc1, pc_next: pc_next_last,
                       exc: fetch.exc, badv: fetch.badv, unknown: fetch.unknown1};

    assign push_e0  = valid0 ? slot0_e : slot1_e;   // oldest surviving word first
    assign push_e1  = slot1_e;
    assign push_cnt = {1'b0, valid0} + {1'b0, valid1};

    assign bp_fb = '{valid: fetch.valid, pc: fetch.pc, target0: target0, target1: target1,
                     cat0: cat0, cat1: cat1};

    fetch_buffer #(
        .BUF_DEPTH(BUF_DEPTH)
    ) u_fetch_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .push_cnt  (push_cnt),
        .push_e0   (push_e0),
        .push_e1   (push_e1),
        .pop_cnt   (read_en),
        .head0     (head0),
        .head1     (head1),
        .head_valid(head_valid),
        .full      (full)
    );

    inst_decoder u_dec0 (.entry(head0), .entry_valid(head_valid[0]), .plv(plv), .slot(out0));
    inst_decoder u_dec1 (.entry(head1), .entry_valid(head_valid[1]), .plv(plv), .slot(out1));

    // flushed queue presents nothing to issue on the next cycle
    a_flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out0.valid && !out1.valid)
        else $error("decode slot valid right after flush");

endmodule

//--- hdl/inst_decoder.sv
// decodes one queued LA32 word into a micro-op with immediate, registers and exception
module inst_decoder (
    input  id_pkg::fetch_entry_t entry,
    input  logic                 entry_valid,
    input  id_pkg::plv_t         plv,
    output id_pkg::dec_slot_t    slot
);

    id_pkg::word_t    inst;
    id_pkg::uop_t     uop;
    id_pkg::word_t    imm;
    id_pkg::reg_idx_t rd;
    id_pkg::exc_t     dec_exc;
    id_pkg::word_t    imm_si12;
    id_pkg::word_t    imm_si20;
    id_pkg::word_t    imm_offs16;
    id_pkg::word_t    imm_offs26;
    logic             known;
    logic             is_syscall;
    logic             is_break;

    assign inst = entry.inst;

    assign imm_si12   = {{20{inst[21]}}, inst[21:10]};
    assign imm_si20   = {inst[24:5], 12'h000};
    assign imm_offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign imm_offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        uop        = id_pkg::uop_none;
        imm        = '0;
        rd         = inst[4:0];
        known      = 1'b1;
        is_syscall = 1'b0;
        is_break   = 1'b0;
        if (inst[31:15] == id_pkg::opc17_add) begin
            uop.op        = id_pkg::op_add;
            uop.writes_rd = 1'b1;
        end else if (inst[31:15] == id_pkg::opc17_sub) begin
            uop.op        = id_pkg::op_sub;
            uop.writes_rd = 1'b1;
        end else if (inst[31:22] == id_pkg::opc10_addi) begin
            uop.op        = id_pkg::op_addi;
            uop.use_imm   = 1'b1;
            uop.writes_rd = 1'b1;
            imm           = imm_si12;
        end else if (inst[31:25] == id_pkg::opc7_lu12i) begin
            uop.op        = id_pkg::op_lu12i;
            uop.use_imm   = 1'b1;
            uop.writes_rd = 1'b1;
            imm           = imm_si20;
        end else if (inst[31:22] == id_pkg::opc10_ld) begin
            uop.op        = id_pkg::op_ld;
            uop.use_imm   = 1'b1;
            uop.writes_rd = 1'b1;
            imm           = imm_si12;
        end else if (inst[31:22] == id_pkg::opc10_st) begin
            uop.op      = id_pkg::op_st;   // rd is the store data source
            uop.use_imm = 1'b1;
            imm         = imm_si12;
        end else if (inst[31:26] == id_pkg::opc6_beq) begin
            uop.op      = id_pkg::op_beq;
            uop.use_imm = 1'b1;
            imm         = imm_offs16;
        end else if (inst[31:26] == id_pkg::opc6_bne) begin
            uop.op      = id_pkg::op_bne;
            uop.use_imm = 1'b1;
            imm         = imm_offs16;
        end else if (inst[31:26] == id_pkg::opc6_b) begin
            uop.op      = id_pkg::op_b;
            uop.use_imm = 1'b1;
            imm         = imm_offs26;
        end else if (inst[31:26] == id_pkg::opc6_bl) begin
            uop.op        = id_pkg::op_bl;
            uop.use_imm   = 1'b1;
            uop.writes_rd = 1'b1;
            imm           = imm_offs26;
            rd            = 5'd1;           // link register
        end else if (inst[31:26] == id_pkg::opc6_jirl) begin
            uop.op        = id_pkg::op_jirl;
            uop.use_imm   = 1'b1;
            uop.writes_rd = 1'b1;
            imm           = imm_offs16;
        end else if (inst[31:15] == id_pkg::opc17_syscall) begin
            uop.op     = id_pkg::op_syscall;
            is_syscall = 1'b1;
        end else if (inst[31:15] == id_pkg::opc17_break) begin
            uop.op   = id_pkg::op_break;
            is_break = 1'b1;
        end else if (inst == id_pkg::inst_ertn) begin
            uop.op         = id_pkg::op_ertn;
            uop.privileged = 1'b1;
        end else begin
            known = 1'b0;
        end
    end

    // fetch-side fault first, then decode faults by priority
    always_comb begin
        if (entry.exc != '0) begin
            dec_exc = entry.exc;
        end else if (!known) begin
            dec_exc = id_pkg::exc_ine;
        end else if (is_syscall) begin
            dec_exc = id_pkg::exc_sys;
        end else if (is_break) begin
            dec_exc = id_pkg::exc_brk;
        end else if (uop.privileged && plv != 2'd0) begin
            dec_exc = id_pkg::exc_ipe;
        end else begin
            dec_exc = '0;
        end
    end

    assign slot.valid   = entry_valid;
    assign slot.uop     = (dec_exc != '0) ? id_pkg::uop_none : uop;   // trap, nothing to execute
    assign slot.imm     = imm;
    assign slot.rd      = rd;
    assign slot.rj      = inst[9:5];
    assign slot.rk      = inst[14:10];
    assign slot.pc      = entry.pc;
    assign slot.pc_next = entry.pc_next;
    assign slot.exc     = dec_exc;
    assign slot.badv    = entry.badv;
    assign slot.unknown = entry.unknown;

endmodule

//--- hdl/pre_decoder.sv
// branch pre-decode of one fetched word, feeds redirect and predictor correction in id_stage
module pre_decoder (
    input  id_pkg::word_t   inst,
    output id_pkg::br_cat_t cat,
    output id_pkg::word_t   offset
);

    logic [5:0]    opc;
    id_pkg::word_t offs16_ext;
    id_pkg::word_t offs26_ext;

    assign opc = inst[31:26];

    // word offsets, already scaled to bytes
    assign offs16_ext = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26_ext = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};  // offs26 high part in [9:0]

    always_comb begin
        cat    = id_pkg::cat_none;
        offset = '0;
        case (opc)
            id_pkg::opc6_beq,
            id_pkg::opc6_bne: begin
                cat    = id_pkg::cat_cond;
                offset = offs16_ext;
            end
            id_pkg::opc6_b,
            id_pkg::opc6_bl: begin
                cat    = id_pkg::cat_direct;
                offset = offs26_ext;
            end
            id_pkg::opc6_jirl: begin
                // target depends on rj, only the offset is known here
                cat    = id_pkg::cat_jirl;
                offset = offs16_ext;
            end
            default: begin
                cat    = id_pkg::cat_none;
                offset = '0;
            end
        endcase
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the id_stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    -f flist.f --top-module tb_id_stage -o tb_id_stage
out=$(./obj_dir/tb_id_stage || true)
echo "$out"
echo "$out" | grep -q "test passed"

//--- sim/tb_id_stage.sv
// testbench for id_stage that applies a decode table and checks pairing, exceptions, redirect, NOP drop and full
module tb_id_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int            NVEC     = 17;
    localparam int            TIMEOUT  = 20;            // cycles per wait
    localparam id_pkg::word_t NOP_WORD = 32'h0280_0000;

    typedef struct packed {
        id_pkg::word_t    inst;
        id_pkg::op_t      op;
        id_pkg::reg_idx_t rd;
        id_pkg::reg_idx_t rj;
        id_pkg::reg_idx_t rk;
        id_pkg::word_t    imm;
        id_pkg::exc_t     exc;
        id_pkg::exc_t     fexc;   // fault carried in from fetch
        id_pkg::plv_t     plv;
    } vec_t;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    id_pkg::fetch_pair_t  fetch;
    id_pkg::plv_t         plv;
    logic [1:0]           read_en;
    logic                 full;
    id_pkg::dec_slot_t    out0;
    id_pkg::dec_slot_t    out1;
    id_pkg::bp_feedback_t bp_fb;
    logic                 set_pc;
    id_pkg::word_t        redirect_pc;

    vec_t              tbl [NVEC];
    id_pkg::dec_slot_t exp_q [$];   // decoded slots still expected in program order
    id_pkg::word_t     rnd;

    id_stage #(.BUF_DEPTH(8)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_slot(input string what, input id_pkg::dec_slot_t got,
                              input id_pkg::dec_slot_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_redirect(input id_pkg::word_t got, input id_pkg::word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t: redirect_pc %h expected %h", $time, got, exp));
        end
    endtask

    task automatic check_feedback(input id_pkg::bp_feedback_t got,
                                  input id_pkg::bp_feedback_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t: bp_fb %h expected %h", $time, got, exp));
        end
    endtask

    task automatic check_full(input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t: full is %b expected %b", $time, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t: %s is %b expected %b", $time, what, got, exp));
        end
    endtask

    function automatic id_pkg::word_t xorshift32(input id_pkg::word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic id_pkg::uop_t expect_uop(input id_pkg::op_t op);
        id_pkg::uop_t u;
        u.op         = op;
        u.use_imm    = op inside {id_pkg::op_addi, id_pkg::op_lu12i, id_pkg::op_ld, id_pkg::op_st,
                                  id_pkg::op_beq, id_pkg::op_bne, id_pkg::op_b, id_pkg::op_bl,
                                  id_pkg::op_jirl};
        u.writes_rd  = op inside {id_pkg::op_add, id_pkg::op_sub, id_pkg::op_addi,
                                  id_pkg::op_lu12i, id_pkg::op_ld, id_pkg::op_bl, id_pkg::op_jirl};
        u.privileged = op == id_pkg::op_ertn;
        return u;
    endfunction

    function automatic id_pkg::br_cat_t expect_cat(input id_pkg::op_t op);
        id_pkg::br_cat_t c;
        case (op)
            id_pkg::op_beq, id_pkg::op_bne: c = id_pkg::cat_cond;
            id_pkg::op_b, id_pkg::op_bl:    c = id_pkg::cat_direct;
            id_pkg::op_jirl:                c = id_pkg::cat_jirl;
            default:                        c = id_pkg::cat_none;
        endcase
        return c;
    endfunction

    // branch targets are pc relative and a plain word reports its slot address
    function automatic id_pkg::bp_feedback_t expect_feedback(input id_pkg::word_t pc,
                                                             input id_pkg::op_t op0,
                                                             input id_pkg::word_t imm0,
                                                             input id_pkg::op_t op1,
                                                             input id_pkg::word_t imm1);
        id_pkg::bp_feedback_t fb;
        fb.valid   = 1'b1;
        fb.pc      = pc;
        fb.cat0    = expect_cat(op0);
        fb.cat1    = expect_cat(op1);
        fb.target0 = pc + ((fb.cat0 == id_pkg::cat_none) ? 32'd0 : imm0);
        fb.target1 = {pc[31:3], 3'b100} + ((fb.cat1 == id_pkg::cat_none) ? 32'd0 : imm1);
        return fb;
    endfunction

    // register fields are plain instruction bits apart from the bl link register
    function automatic vec_t make_vec(input id_pkg::word_t inst, input id_pkg::op_t op,
                                      input id_pkg::word_t imm, input id_pkg::exc_t exc);
        vec_t v;
        v.inst = inst;
        v.op   = (exc != '0) ? id_pkg::op_none : op;   // traps carry no operation
        v.rd   = (op == id_pkg::op_bl) ? 5'd1 : inst[4:0];
        v.rj   = inst[9:5];
        v.rk   = inst[14:10];
        v.imm  = imm;
        v.exc  = exc;
        v.fexc = '0;
        v.plv  = 2'd0;
        return v;
    endfunction

    function automatic id_pkg::dec_slot_t expect_slot(input vec_t v, input id_pkg::word_t pc,
                                                      input id_pkg::word_t pc_next,
                                                      input logic unk, input id_pkg::word_t badv);
        id_pkg::dec_slot_t s;
        s.valid   = 1'b1;
        s.uop     = expect_uop(v.op);
        s.imm     = v.imm;
        s.rd      = v.rd;
        s.rj      = v.rj;
        s.rk      = v.rk;
        s.pc      = pc;
        s.pc_next = pc_next;
        s.exc     = v.exc;
        s.badv    = badv;
        s.unknown = unk;
        return s;
    endfunction

    function automatic id_pkg::fetch_pair_t make_group(input id_pkg::word_t pc,
                                                       input id_pkg::word_t i0,
                                                       input id_pkg::word_t i1, input logic unk0,
                                                       input id_pkg::exc_t fexc);
        id_pkg::fetch_pair_t f;
        f           = '0;
        f.valid     = 1'b1;
        f.inst0     = i0;
        f.inst1     = i1;
        f.pc        = pc;
        f.pc_next   = {pc[31:3], 3'b000} + 32'd8;   // next sequential group
        f.exc       = fexc;
        f.badv      = ~pc;
        f.unknown0  = unk0;
        return f;
    endfunction

    function automatic logic heads_ready(input int n);
        return out0.valid && (n == 1 || out1.valid);
    endfunction

    task automatic build_table();
        id_pkg::word_t fields;   // rk rj rd
        id_pkg::word_t r;
        int            s12;
        int            s16;
        int            s26;
        for (int k = 0; k < NVEC; k++) begin
            rnd    = xorshift32(rnd);
            fields = {17'd0, rnd[14:1], 1'b1};   // odd rd keeps addi off the NOP word
            s12    = int'(rnd[26:15]) - 2048;
            rnd    = xorshift32(rnd);
            r      = rnd;
            s16    = int'(r[15:0]) - 32768;
            s26    = int'(r[25:0]) - 33554432;
            case (k)
                0: tbl[k] = make_vec(32'h0010_0000 | fields, id_pkg::op_add, '0, '0);
                1: tbl[k] = make_vec(32'h0011_0000 | fields, id_pkg::op_sub, '0, '0);
                2: tbl[k] = make_vec(32'h0280_0000 | {s12[11:0], fields[9:0]}, id_pkg::op_addi,
                                     id_pkg::word_t'(s12), '0);
                3: tbl[k] = make_vec(32'h1400_0000 | {r[31:12], fields[4:0]}, id_pkg::op_lu12i,
                                     {r[31:12], 12'h000}, '0);
                4: tbl[k] = make_vec(32'h2880_0000 | {s12[11:0], fields[9:0]}, id_pkg::op_ld,
                                     id_pkg::word_t'(s12), '0);
                5: tbl[k] = make_vec(32'h2980_0000 | {s12[11:0], fields[9:0]}, id_pkg::op_st,
                                     id_pkg::word_t'(s12), '0);
                6: tbl[k] = make_vec(32'h5800_0000 | {s16[15:0], fields[9:0]}, id_pkg::op_beq,
                                     id_pkg::word_t'(s16 * 4), '0);
                7: tbl[k] = make_vec(32'h5c00_0000 | {s16[15:0], fields[9:0]}, id_pkg::op_bne,
                                     id_pkg::word_t'(s16 * 4), '0);
                8: tbl[k] = make_vec(32'h5000_0000 | {s26[15:0], s26[25:16]}, id_pkg::op_b,
                                     id_pkg::word_t'(s26 * 4), '0);
                9: tbl[k] = make_vec(32'h5400_0000 | {s26[15:0], s26[25:16]}, id_pkg::op_bl,
                                     id_pkg::word_t'(s26 * 4), '0);
                10: tbl[k] = make_vec(32'h4c00_0000 | {s16[15:0], fields[9:0]}, id_pkg::op_jirl,
                                      id_pkg::word_t'(s16 * 4), '0);
                11: tbl[k] = make_vec(32'h002b_0000 | fields, id_pkg::op_syscall, '0,
                                      id_pkg::exc_sys);
                12: tbl[k] = make_vec(32'h002a_0000 | fields, id_pkg::op_break, '0,
                                      id_pkg::exc_brk);
                13: tbl[k] = make_vec(32'h0648_3800, id_pkg::op_ertn, '0, '0);
                14: begin
                    tbl[k]     = make_vec(32'h0648_3800, id_pkg::op_ertn, '0, id_pkg::exc_ipe);
                    tbl[k].plv = 2'd3;   // user mode
                end
                15: tbl[k] = make_vec(32'hfc00_0000 | fields, id_pkg::op_none, '0,
                                      id_pkg::exc_ine);
                default: begin
                    tbl[k]      = make_vec(32'h0010_0000 | fields, id_pkg::op_add, '0, 7'h08);
                    tbl[k].fexc = 7'h08;   // fetch fault wins over a clean decode
                end
            endcase
        end
    endtask

    // drive one group for a cycle and check redirect and feedback while it is on the inputs
    task automatic send_group(input id_pkg::fetch_pair_t f, input logic exp_set,
                              input id_pkg::word_t exp_pc, input id_pkg::bp_feedback_t exp_fb);
        @(negedge clk);
        fetch = f;
        #1;
        check_flag("set_pc", set_pc, exp_set);
        if (exp_set) begin
            check_redirect(redirect_pc, exp_pc);
        end
        check_feedback(bp_fb, exp_fb);
        @(negedge clk);
        fetch.valid = 1'b0;
    endtask

    task automatic pop_slots(input int n);
        for (int i = 0; i < TIMEOUT; i++) begin
            if (heads_ready(n)) begin
                break;
            end
            @(negedge clk);
        end
        if (!heads_ready(n)) begin
            stop_run("timeout while waiting for valid decode slots");
        end else begin
            check_slot("out0", out0, exp_q[0]);
            if (n == 2) begin
                check_slot("out1", out1, exp_q[1]);
            end
            read_en = 2'(n);
            @(negedge clk);
            read_en = 2'd0;
            for (int i = 0; i < n; i++) begin
                void'(exp_q.pop_front());
            end
        end
    endtask

    initial begin
        id_pkg::fetch_pair_t f;
        id_pkg::word_t       pc;
        vec_t                v;
        rst_n   = 1'b0;
        flush   = 1'b0;
        fetch   = '0;
        plv     = 2'd0;
        read_en = 2'd0;
        rnd     = 32'd38;
        build_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_full(full, 1'b0);
        check_flag("set_pc after reset", set_pc, 1'b0);
        check_flag("out0.valid after reset", out0.valid, 1'b0);
        check_flag("out1.valid after reset", out1.valid, 1'b0);

        // every vector alone in slot 1 with exceptions included
        for (int k = 0; k < NVEC; k++) begin
            pc  = 32'h1c00_0004 + 32'(k * 8);
            plv = tbl[k].plv;
            f   = make_group(pc, 32'h0, tbl[k].inst, 1'b0, tbl[k].fexc);
            send_group(f, 1'b0, '0,
                       expect_feedback(pc, id_pkg::op_none, '0, tbl[k].op, tbl[k].imm));
            exp_q.push_back(expect_slot(tbl[k], pc, f.pc_next, 1'b0, f.badv));
            pop_slots(1);
        end
        plv = 2'd0;

        // aligned pairs with uneven pops
        for (int k = 0; k < 6; k += 2) begin
            pc = 32'h1c00_1000 + 32'(k * 4);
            f  = make_group(pc, tbl[k].inst, tbl[k+1].inst, 1'b0, '0);
            send_group(f, 1'b0, '0,
                       expect_feedback(pc, tbl[k].op, tbl[k].imm, tbl[k+1].op, tbl[k+1].imm));
            exp_q.push_back(expect_slot(tbl[k], pc, pc + 32'd4, 1'b0, f.badv));
            exp_q.push_back(expect_slot(tbl[k+1], pc + 32'd4, f.pc_next, 1'b0, f.badv));
        end
        pop_slots(1);
        pop_slots(2);
        pop_slots(1);
        pop_slots(2);
        check_flag("out0.valid when drained", out0.valid, 1'b0);

        // unknown b in slot 0 drops the fall-through word
        pc = 32'h1c00_2000;
        f  = make_group(pc, tbl[8].inst, tbl[0].inst, 1'b1, '0);
        send_group(f, 1'b1, pc + tbl[8].imm,
                   expect_feedback(pc, tbl[8].op, tbl[8].imm, tbl[0].op, tbl[0].imm));
        exp_q.push_back(expect_slot(tbl[8], pc, pc + tbl[8].imm, 1'b1, f.badv));
        pop_slots(1);
        check_flag("slot 1 after taken b", out0.valid, 1'b0);

        // backward beq 4 words back
        v = make_vec(32'h5bff_f0a5, id_pkg::op_beq, 32'hffff_fff0, '0);
        f = make_group(pc + 32'd8, v.inst, tbl[1].inst, 1'b1, '0);
        send_group(f, 1'b1, pc - 32'd8,
                   expect_feedback(pc + 32'd8, v.op, v.imm, tbl[1].op, tbl[1].imm));
        exp_q.push_back(expect_slot(v, pc + 32'd8, pc - 32'd8, 1'b1, f.badv));
        pop_slots(1);
        check_flag("slot 1 after taken beq", out0.valid, 1'b0);

        // forward beq is predicted not taken
        v = make_vec(32'h5800_40a5, id_pkg::op_beq, 32'h0000_0040, '0);
        f = make_group(pc + 32'd16, v.inst, tbl[1].inst, 1'b1, '0);
        send_group(f, 1'b0, '0,
                   expect_feedback(pc + 32'd16, v.op, v.imm, tbl[1].op, tbl[1].imm));
        exp_q.push_back(expect_slot(v, pc + 32'd16, pc + 32'd20, 1'b1, f.badv));
        exp_q.push_back(expect_slot(tbl[1], pc + 32'd20, f.pc_next, 1'b0, f.badv));
        pop_slots(2);

        // NOP words never reach the queue
        pc = 32'h1c00_3000;
        f  = make_group(pc, NOP_WORD, tbl[1].inst, 1'b0, '0);
        send_group(f, 1'b0, '0,
                   expect_feedback(pc, id_pkg::op_none, '0, tbl[1].op, tbl[1].imm));
        exp_q.push_back(expect_slot(tbl[1], pc + 32'd4, f.pc_next, 1'b0, f.badv));
        f = make_group(pc + 32'd8, tbl[2].inst, NOP_WORD, 1'b0, '0);
        send_group(f, 1'b0, '0,
                   expect_feedback(pc + 32'd8, tbl[2].op, tbl[2].imm, id_pkg::op_none, '0));
        exp_q.push_back(expect_slot(tbl[2], pc + 32'd8, f.pc_next, 1'b0, f.badv));
        pop_slots(1);
        pop_slots(1);
        check_flag("out0.valid after NOP groups", out0.valid, 1'b0);

        // fill without popping and flush
        check_full(full, 1'b0);
        for (int k = 0; k < 5 && !full; k++) begin
            f = make_group(32'h1c00_4000 + 32'(k * 8), tbl[0].inst, tbl[1].inst, 1'b0, '0);
            send_group(f, 1'b0, '0,
                       expect_feedback(f.pc, tbl[0].op, tbl[0].imm, tbl[1].op, tbl[1].imm));
        end
        check_full(full, 1'b1);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_flag("out0.valid after flush", out0.valid, 1'b0);
        check_flag("out1.valid after flush", out1.valid, 1'b0);
        check_full(full, 1'b0);

        $display("test passed");
        $finish;
    end

endmodule
